//--- common/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Byte address width whose top bit selects the CSR space
`define CACHE_ADDR_W 32

// Word width
`define CACHE_DATA_W 32

// Geometry
`define CACHE_LINES 16
`define CACHE_WORDS 4

// Most memory requests that may be outstanding
`define CACHE_MEM_CREDITS 2

// CSR word index width and map
`define CACHE_CSR_ADDR_W 2
`define CACHE_CSR_HITS 0
`define CACHE_CSR_MISSES 1
`define CACHE_CSR_INVALIDATE 2

`endif

//--- common/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

  // Field widths derived from the geometry
  localparam int BYTE_OFF_W = $clog2(`CACHE_DATA_W / 8);
  localparam int OFFSET_W   = $clog2(`CACHE_WORDS);
  localparam int INDEX_W    = $clog2(`CACHE_LINES);
  localparam int INDEX_LSB  = BYTE_OFF_W + OFFSET_W;

  // Cache space is one bit narrower than the bus address
  localparam int TAG_W      = `CACHE_ADDR_W - 1 - INDEX_W - OFFSET_W;

  // Line index
  typedef logic [INDEX_W-1:0] index_t;

  // Word within a line
  typedef logic [OFFSET_W-1:0] offset_t;

  // Tag, taken as the top TAG_W bits of the cache address
  typedef logic [TAG_W-1:0] tag_t;

  // One data word and its byte strobes
  typedef logic [`CACHE_DATA_W-1:0] word_t;
  typedef logic [`CACHE_DATA_W/8-1:0] strb_t;

  // Controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    FILL,
    WRITE,
    RESPOND
  } ctrl_state_t;

endpackage

//--- front_end/cache_front_end.sv
`timescale 1ns/10ps

`include "cache_macros.svh"

module cache_front_end (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // IOb slave side
  input  logic                          iob_valid_i,
  input  logic [`CACHE_ADDR_W-1:0]      iob_addr_i,
  input  cache_pkg::word_t              iob_wdata_i,
  input  cache_pkg::strb_t              iob_wstrb_i,
  output logic                          iob_ready_o,
  output logic                          iob_rvalid_o,
  output cache_pkg::word_t              iob_rdata_o,
  // Cache array requests
  output logic                          data_req_o,
  output logic [`CACHE_ADDR_W-2:0]      data_addr_o,
  output cache_pkg::word_t              data_wdata_o,
  output cache_pkg::strb_t              data_wstrb_o,
  output logic                          data_we_o,
  input  cache_pkg::word_t              data_rdata_i,
  input  logic                          data_ack_i,
  // CSR requests
  output logic                          ctrl_req_o,
  output logic [`CACHE_CSR_ADDR_W-1:0]  ctrl_addr_o,
  output cache_pkg::word_t              ctrl_wdata_o,
  input  cache_pkg::word_t              ctrl_rdata_i,
  input  logic                          ctrl_ack_i
);

  import cache_pkg::*;

  logic                     accept;
  logic                     ack;
  logic                     pending_q;
  logic                     is_ctrl_q;
  logic                     we_q;
  logic [`CACHE_ADDR_W-2:0] addr_q;
  word_t                    wdata_q;
  strb_t                    wstrb_q;

  assign ack    = data_ack_i | ctrl_ack_i;
  assign accept = iob_valid_i & iob_ready_o;

  // Free when idle, or in the cycle the pending request closes
  assign iob_ready_o = ~pending_q | ack;

  // Writes complete silently
  assign iob_rvalid_o = ack & ~we_q;
  assign iob_rdata_o  = ctrl_ack_i ? ctrl_rdata_i : data_rdata_i;

  // Pending flag and request kind
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
      is_ctrl_q <= 1'b0;
      we_q      <= 1'b0;
    end else if (accept) begin
      pending_q <= 1'b1;
      is_ctrl_q <= iob_addr_i[`CACHE_ADDR_W-1];
      we_q      <= |iob_wstrb_i;
    end else if (ack) begin
      pending_q <= 1'b0;
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= iob_addr_i[`CACHE_ADDR_W-2:0];
      wdata_q <= iob_wdata_i;
      wstrb_q <= iob_wstrb_i;
    end
  end

  assign data_req_o   = pending_q & ~is_ctrl_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;
  assign data_wstrb_o = wstrb_q;
  assign data_we_o    = we_q;

  // CSRs are word addressed
  assign ctrl_req_o   = pending_q & is_ctrl_q;
  assign ctrl_addr_o  = addr_q[`CACHE_CSR_ADDR_W+BYTE_OFF_W-1:BYTE_OFF_W];
  assign ctrl_wdata_o = wdata_q;

  // Acks only ever close a request that is actually open
  a_ack_pending : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (data_ack_i | ctrl_ack_i) |-> pending_q
  );

endmodule

//--- hdl/cache_memory.sv
`timescale 1ns/10ps

`include "cache_macros.svh"

module cache_memory (
  input  logic               clk_i,
  input  logic               reset_i,
  // Lookup
  input  cache_pkg::index_t  index_i,
  input  cache_pkg::offset_t offset_i,
  input  cache_pkg::tag_t    tag_i,
  output logic               hit_o,
  output cache_pkg::word_t   rdata_o,
  // Hit write
  input  logic               word_we_i,
  input  cache_pkg::word_t   wdata_i,
  input  cache_pkg::strb_t   wstrb_i,
  // Line fill
  input  logic               fill_valid_i,
  input  cache_pkg::offset_t fill_offset_i,
  input  cache_pkg::word_t   fill_data_i,
  input  logic               fill_commit_i,
  input  logic               inval_all_i
);

  import cache_pkg::*;

  localparam int NBYTES = `CACHE_DATA_W / 8;

  logic [`CACHE_LINES-1:0] valid_q;
  tag_t                    tag_q  [`CACHE_LINES];
  word_t                   data_q [`CACHE_LINES][`CACHE_WORDS];

  // Hit detection and read port
  assign hit_o   = valid_q[index_i] && (tag_q[index_i] == tag_i);
  assign rdata_o = data_q[index_i][offset_i];

  // Valid bits
  always_ff @(posedge clk_i) begin
    if (reset_i || inval_all_i) begin
      valid_q <= '0;
    end else if (fill_commit_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  // Tag written with the valid bit at the end of a fill
  always_ff @(posedge clk_i) begin
    if (fill_commit_i) begin
      tag_q[index_i] <= tag_i;
    end
  end

  // Data array
  // Fill words land as they arrive and hit writes merge strobed bytes
  always_ff @(posedge clk_i) begin
    if (fill_valid_i) begin
      data_q[index_i][fill_offset_i] <= fill_data_i;
    end else if (word_we_i) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (wstrb_i[b]) begin
          data_q[index_i][offset_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- hdl/cache_control.sv
`timescale 1ns/10ps

`include "cache_macros.svh"

module cache_control (
  input  logic                         clk_i,
  input  logic                         reset_i,
  // Data requests
  input  logic                         data_req_i,
  input  logic [`CACHE_ADDR_W-2:0]     data_addr_i,
  input  logic                         data_we_i,
  output logic                         data_ack_o,
  output cache_pkg::word_t             data_rdata_o,
  // CSR requests
  input  logic                         ctrl_req_i,
  input  logic [`CACHE_CSR_ADDR_W-1:0] ctrl_addr_i,
  input  cache_pkg::word_t             ctrl_wdata_i,
  output logic                         ctrl_ack_o,
  output cache_pkg::word_t             ctrl_rdata_o,
  // Arrays
  input  logic                         hit_i,
  input  cache_pkg::word_t             mem_word_i,
  output logic                         word_we_o,
  output logic                         fill_commit_o,
  output logic                         inval_all_o,
  // Back end
  output logic                         fill_start_o,
  output logic [`CACHE_ADDR_W-2:0]     fill_base_o,
  input  logic                         fill_done_i,
  output logic                         wt_start_o,
  input  logic                         wt_done_i
);

  import cache_pkg::*;

  localparam logic [`CACHE_CSR_ADDR_W-1:0] CSR_HITS   = `CACHE_CSR_HITS;
  localparam logic [`CACHE_CSR_ADDR_W-1:0] CSR_MISSES = `CACHE_CSR_MISSES;
  localparam logic [`CACHE_CSR_ADDR_W-1:0] CSR_INVAL  = `CACHE_CSR_INVALIDATE;

  ctrl_state_t state_q, state_d;
  logic        rd_lookup;
  logic        csr_wr;
  word_t       hits_q, misses_q;

  // Line base of the current request
  assign fill_base_o  = {data_addr_i[`CACHE_ADDR_W-2:INDEX_LSB], {INDEX_LSB{1'b0}}};
  assign data_rdata_o = mem_word_i;

  always_comb begin
    state_d       = state_q;
    data_ack_o    = 1'b0;
    word_we_o     = 1'b0;
    fill_start_o  = 1'b0;
    fill_commit_o = 1'b0;
    wt_start_o    = 1'b0;
    case (state_q)
      IDLE: if (data_req_i) state_d = LOOKUP;
      LOOKUP: begin
        if (data_we_i) begin
          // No write allocate so only a resident line is updated
          word_we_o  = hit_i;
          wt_start_o = 1'b1;
          state_d    = WRITE;
        end else if (hit_i) begin
          data_ack_o = 1'b1;
          state_d    = IDLE;
        end else begin
          fill_start_o = 1'b1;
          state_d      = FILL;
        end
      end
      FILL: begin
        if (fill_done_i) begin
          fill_commit_o = 1'b1;
          state_d       = RESPOND;
        end
      end
      WRITE: begin
        if (wt_done_i) begin
          data_ack_o = 1'b1;
          state_d    = IDLE;
        end
      end
      RESPOND: begin
        data_ack_o = 1'b1;
        state_d    = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) state_q <= IDLE;
    else state_q <= state_d;
  end

  // CSRs answer in the cycle they are seen
  assign rd_lookup   = (state_q == LOOKUP) & ~data_we_i;
  assign csr_wr      = ctrl_req_i & data_we_i;
  assign ctrl_ack_o  = ctrl_req_i;
  assign inval_all_o = csr_wr & (ctrl_addr_i == CSR_INVAL);

  always_comb begin
    case (ctrl_addr_i)
      CSR_HITS:   ctrl_rdata_o = hits_q;
      CSR_MISSES: ctrl_rdata_o = misses_q;
      default:    ctrl_rdata_o = '0;
    endcase
  end

  // Counters may also be preset by a CSR write
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hits_q   <= '0;
      misses_q <= '0;
    end else begin
      if (csr_wr && ctrl_addr_i == CSR_HITS) hits_q <= ctrl_wdata_i;
      else if (rd_lookup && hit_i) hits_q <= hits_q + 1'b1;
      if (csr_wr && ctrl_addr_i == CSR_MISSES) misses_q <= ctrl_wdata_i;
      else if (rd_lookup && !hit_i) misses_q <= misses_q + 1'b1;
    end
  end

  // Starts never overlap and every done answers its own start
  a_one_start : assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(fill_start_o && wt_start_o) &&
    (!fill_done_i || state_q == FILL) &&
    (!wt_done_i || state_q == WRITE)
  );

endmodule

//--- hdl/cache_back_end.sv
`timescale 1ns/10ps

`include "cache_macros.svh"

module cache_back_end (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // Fill handshake
  input  logic                     fill_start_i,
  input  logic [`CACHE_ADDR_W-2:0] fill_base_i,
  output logic                     fill_done_o,
  // Write-through handshake
  input  logic                     wt_start_i,
  input  logic [`CACHE_ADDR_W-2:0] wt_addr_i,
  input  cache_pkg::word_t         wt_wdata_i,
  input  cache_pkg::strb_t         wt_wstrb_i,
  output logic                     wt_done_o,
  // Fill words to the arrays
  output logic                     fill_valid_o,
  output cache_pkg::offset_t       fill_offset_o,
  output cache_pkg::word_t         fill_data_o,
  // External memory
  output logic                     mem_req_o,
  output logic                     mem_we_o,
  output logic [`CACHE_ADDR_W-2:0] mem_addr_o,
  output cache_pkg::word_t         mem_wdata_o,
  output cache_pkg::strb_t         mem_wstrb_o,
  input  cache_pkg::word_t         mem_rdata_i,
  input  logic                     mem_rvalid_i,
  input  logic                     mem_credit_i
);

  import cache_pkg::*;

  localparam int CREDIT_W = $clog2(`CACHE_MEM_CREDITS + 1);
  localparam int CNT_W    = OFFSET_W + 1;
  localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`CACHE_MEM_CREDITS);
  localparam logic [CNT_W-1:0]    LINE_WORDS = CNT_W'(`CACHE_WORDS);

  logic [CREDIT_W-1:0]      credit_q;
  logic [CNT_W-1:0]         issue_cnt_q;
  offset_t                  recv_q;
  logic                     fill_active_q;
  logic                     wt_pending_q;
  logic [`CACHE_ADDR_W-2:0] base_q;
  logic                     have_credit;
  logic                     fill_issue;
  logic                     wt_issue;

  assign have_credit = (credit_q != '0);
  assign fill_issue  = fill_active_q & (issue_cnt_q != LINE_WORDS) & have_credit;
  assign wt_issue    = wt_pending_q & have_credit;

  assign mem_req_o   = fill_issue | wt_issue;
  assign mem_we_o    = wt_issue;
  assign mem_wdata_o = wt_wdata_i;
  assign mem_wstrb_o = wt_issue ? wt_wstrb_i : '0;
  assign mem_addr_o  = wt_pending_q ?
                       {wt_addr_i[`CACHE_ADDR_W-2:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}} :
                       {base_q[`CACHE_ADDR_W-2:INDEX_LSB], issue_cnt_q[OFFSET_W-1:0],
                        {BYTE_OFF_W{1'b0}}};

  assign wt_done_o = wt_issue;

  // Data returns in issue order, so arrival count gives the offset
  assign fill_valid_o  = fill_active_q & mem_rvalid_i;
  assign fill_offset_o = recv_q;
  assign fill_data_o   = mem_rdata_i;
  assign fill_done_o   = fill_valid_o & (recv_q == offset_t'(`CACHE_WORDS - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fill_active_q <= 1'b0;
      issue_cnt_q   <= '0;
      recv_q        <= '0;
    end else if (fill_start_i) begin
      fill_active_q <= 1'b1;
      issue_cnt_q   <= '0;
      recv_q        <= '0;
    end else begin
      if (fill_issue) issue_cnt_q <= issue_cnt_q + 1'b1;
      if (fill_valid_o) recv_q <= recv_q + 1'b1;
      if (fill_done_o) fill_active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_start_i) base_q <= fill_base_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) wt_pending_q <= 1'b0;
    else if (wt_start_i) wt_pending_q <= 1'b1;
    else if (wt_issue) wt_pending_q <= 1'b0;
  end

  // One credit per issue, one back per credit pulse
  always_ff @(posedge clk_i) begin
    if (reset_i) credit_q <= CREDIT_MAX;
    else if (mem_req_o && !mem_credit_i) credit_q <= credit_q - 1'b1;
    else if (!mem_req_o && mem_credit_i) credit_q <= credit_q + 1'b1;
  end

  // Memory never hands back more credits than were taken
  a_credit_range : assert property (
    @(posedge clk_i) disable iff (reset_i)
    credit_q <= CREDIT_MAX
  );

endmodule

//--- hdl/cache_top.sv
`timescale 1ns/10ps

`include "cache_macros.svh"

module cache_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // IOb slave
  input  logic                     iob_valid_i,
  input  logic [`CACHE_ADDR_W-1:0] iob_addr_i,
  input  cache_pkg::word_t         iob_wdata_i,
  input  cache_pkg::strb_t         iob_wstrb_i,
  output logic                     iob_ready_o,
  output logic                     iob_rvalid_o,
  output cache_pkg::word_t         iob_rdata_o,
  // External memory
  output logic                     mem_req_o,
  output logic                     mem_we_o,
  output logic [`CACHE_ADDR_W-2:0] mem_addr_o,
  output cache_pkg::word_t         mem_wdata_o,
  output cache_pkg::strb_t         mem_wstrb_o,
  input  cache_pkg::word_t         mem_rdata_i,
  input  logic                     mem_rvalid_i,
  input  logic                     mem_credit_i
);

  import cache_pkg::*;

  logic                         data_req, data_we, data_ack;
  logic [`CACHE_ADDR_W-2:0]     data_addr;
  word_t                        data_wdata, data_rdata;
  strb_t                        data_wstrb;
  logic                         ctrl_req, ctrl_ack;
  logic [`CACHE_CSR_ADDR_W-1:0] ctrl_addr;
  word_t                        ctrl_wdata, ctrl_rdata;
  logic                         hit, word_we, fill_commit, inval_all;
  word_t                        mem_word;
  logic                         fill_start, fill_done, wt_start, wt_done;
  logic [`CACHE_ADDR_W-2:0]     fill_base;
  logic                         fill_valid;
  offset_t                      fill_offset;
  word_t                        fill_data;

  cache_front_end front_end_i (
    .clk_i, .reset_i,
    .iob_valid_i, .iob_addr_i, .iob_wdata_i, .iob_wstrb_i,
    .iob_ready_o, .iob_rvalid_o, .iob_rdata_o,
    .data_req_o(data_req), .data_addr_o(data_addr), .data_wdata_o(data_wdata),
    .data_wstrb_o(data_wstrb), .data_we_o(data_we),
    .data_rdata_i(data_rdata), .data_ack_i(data_ack),
    .ctrl_req_o(ctrl_req), .ctrl_addr_o(ctrl_addr), .ctrl_wdata_o(ctrl_wdata),
    .ctrl_rdata_i(ctrl_rdata), .ctrl_ack_i(ctrl_ack)
  );

  // Address fields sliced straight off the registered request
  cache_memory memory_i (
    .clk_i, .reset_i,
    .index_i(data_addr[INDEX_LSB +: INDEX_W]),
    .offset_i(data_addr[BYTE_OFF_W +: OFFSET_W]),
    .tag_i(data_addr[`CACHE_ADDR_W-2 -: TAG_W]),
    .hit_o(hit), .rdata_o(mem_word),
    .word_we_i(word_we), .wdata_i(data_wdata), .wstrb_i(data_wstrb),
    .fill_valid_i(fill_valid), .fill_offset_i(fill_offset), .fill_data_i(fill_data),
    .fill_commit_i(fill_commit), .inval_all_i(inval_all)
  );

  cache_control control_i (
    .clk_i, .reset_i,
    .data_req_i(data_req), .data_addr_i(data_addr), .data_we_i(data_we),
    .data_ack_o(data_ack), .data_rdata_o(data_rdata),
    .ctrl_req_i(ctrl_req), .ctrl_addr_i(ctrl_addr), .ctrl_wdata_i(ctrl_wdata),
    .ctrl_ack_o(ctrl_ack), .ctrl_rdata_o(ctrl_rdata),
    .hit_i(hit), .mem_word_i(mem_word),
    .word_we_o(word_we), .fill_commit_o(fill_commit), .inval_all_o(inval_all),
    .fill_start_o(fill_start), .fill_base_o(fill_base), .fill_done_i(fill_done),
    .wt_start_o(wt_start), .wt_done_i(wt_done)
  );

  cache_back_end back_end_i (
    .clk_i, .reset_i,
    .fill_start_i(fill_start), .fill_base_i(fill_base), .fill_done_o(fill_done),
    .wt_start_i(wt_start), .wt_addr_i(data_addr), .wt_wdata_i(data_wdata),
    .wt_wstrb_i(data_wstrb), .wt_done_o(wt_done),
    .fill_valid_o(fill_valid), .fill_offset_o(fill_offset), .fill_data_o(fill_data),
    .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_wstrb_o,
    .mem_rdata_i, .mem_rvalid_i, .mem_credit_i
  );

endmodule

//--- dv/cache_mem_model.sv
`timescale 1ns/10ps

`include "cache_macros.svh"

module cache_mem_model #(
  parameter int WORDS = 128
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     mem_req_i,
  input  logic                     mem_we_i,
  input  logic [`CACHE_ADDR_W-2:0] mem_addr_i,
  input  cache_pkg::word_t         mem_wdata_i,
  input  cache_pkg::strb_t         mem_wstrb_i,
  output cache_pkg::word_t         mem_rdata_o,
  output logic                     mem_rvalid_o,
  output logic                     mem_credit_o,
  output logic                     credit_err_o,
  output logic                     addr_err_o,
  output int                       writes_o
);

  import cache_pkg::*;

  localparam int AW = $clog2(WORDS);

  word_t         mem_q [WORDS];
  word_t         rd_data_q [$];
  int            rd_due_q [$];
  int            credit_due_q [$];
  int            cycle;
  int            outstanding;
  int            hold;
  int            k;
  word_t         rd_word;
  logic [AW-1:0] widx;

  // Fill pattern mixes every address bit
  initial begin
    mem_rdata_o  <= '0;
    mem_rvalid_o <= 1'b0;
    mem_credit_o <= 1'b0;
    for (int i = 0; i < WORDS; i++) begin
      mem_q[i] = 32'h5A0F_3C00 ^ (i * 32'h9E37_79B1);
    end
  end

  always @(posedge clk_i) begin
    mem_rvalid_o <= 1'b0;
    mem_credit_o <= 1'b0;
    if (reset_i) begin
      rd_data_q.delete();
      rd_due_q.delete();
      credit_due_q.delete();
      cycle        = 0;
      outstanding  = 0;
      hold         = 0;
      mem_rdata_o  <= '0;
      credit_err_o <= 1'b0;
      addr_err_o   <= 1'b0;
      writes_o     <= 0;
    end else begin
      cycle++;
      // Last cycle's credit pulse has now been seen by the DUT
      if (mem_credit_o) outstanding--;
      if (mem_req_i) begin
        outstanding++;
        if (outstanding > `CACHE_MEM_CREDITS) credit_err_o <= 1'b1;
        if (mem_addr_i >= 31'(4 * WORDS)) addr_err_o <= 1'b1;
        widx = mem_addr_i[AW+1:2];
        if (mem_we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (mem_wstrb_i[b]) mem_q[widx][8*b +: 8] = mem_wdata_i[8*b +: 8];
          end
          writes_o <= writes_o + 1;
        end else begin
          rd_data_q.push_back(mem_q[widx]);
          rd_due_q.push_back(cycle + $urandom_range(1, 4));
        end
        credit_due_q.push_back(cycle + $urandom_range(0, 5));
      end
      // Read data strictly in issue order
      if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
        rd_word = rd_data_q.pop_front();
        void'(rd_due_q.pop_front());
        mem_rvalid_o <= 1'b1;
        mem_rdata_o  <= rd_word;
      end
      // Now and then hold all credits back for a long stretch
      if (hold > 0) hold--;
      else if ($urandom_range(0, 99) < 4) hold = $urandom_range(10, 40);
      if (hold == 0) begin
        k = -1;
        for (int i = credit_due_q.size() - 1; i >= 0; i--) begin
          if (credit_due_q[i] <= cycle) k = i;
        end
        if (k >= 0) begin
          credit_due_q.delete(k);
          mem_credit_o <= 1'b1;
        end
      end
    end
  end

endmodule

//--- dv/cache_tb.sv
`timescale 1ns/10ps

`include "cache_macros.svh"

module cache_tb;

  import cache_pkg::*;

  localparam int TIMEOUT    = 2000;
  localparam int NUM_OPS    = 400;
  localparam int ADDR_WORDS = 96;
  localparam int MEM_WORDS  = 128;
  localparam logic [31:0] CSR_BASE = 32'h8000_0000;

  logic                     clk_i = 1'b0;
  logic                     reset_i;
  logic                     iob_valid_i;
  logic [`CACHE_ADDR_W-1:0] iob_addr_i;
  word_t                    iob_wdata_i;
  strb_t                    iob_wstrb_i;
  logic                     iob_ready_o;
  logic                     iob_rvalid_o;
  word_t                    iob_rdata_o;
  logic                     mem_req_o;
  logic                     mem_we_o;
  logic [`CACHE_ADDR_W-2:0] mem_addr_o;
  word_t                    mem_wdata_o;
  strb_t                    mem_wstrb_o;
  word_t                    mem_rdata_i;
  logic                     mem_rvalid_i;
  logic                     mem_credit_i;
  logic                     credit_err;
  logic                     addr_err;
  int                       mem_writes;

  // Reference models of memory contents and cache residency
  word_t shadow [MEM_WORDS];
  logic  line_valid [`CACHE_LINES];
  int    line_tag [`CACHE_LINES];
  int    exp_hits;
  int    exp_misses;
  int    exp_writes;

  always #50 clk_i = ~clk_i;

  cache_top cache_top_i (
    .clk_i, .reset_i,
    .iob_valid_i, .iob_addr_i, .iob_wdata_i, .iob_wstrb_i,
    .iob_ready_o, .iob_rvalid_o, .iob_rdata_o,
    .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_wstrb_o,
    .mem_rdata_i, .mem_rvalid_i, .mem_credit_i
  );

  cache_mem_model #(.WORDS(MEM_WORDS)) mem_model_i (
    .clk_i, .reset_i,
    .mem_req_i(mem_req_o), .mem_we_i(mem_we_o), .mem_addr_i(mem_addr_o),
    .mem_wdata_i(mem_wdata_o), .mem_wstrb_i(mem_wstrb_o),
    .mem_rdata_o(mem_rdata_i), .mem_rvalid_o(mem_rvalid_i), .mem_credit_o(mem_credit_i),
    .credit_err_o(credit_err), .addr_err_o(addr_err), .writes_o(mem_writes)
  );

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL at %0t: %s got %h, expected %h", $time, name, got, exp));
    end
  endtask

  // One IOb request, from presenting it to its ack cycle
  task automatic transact(input logic [31:0] addr, input word_t wdata, input strb_t wstrb,
                          output word_t rdata, output int lat);
    int n;
    @(posedge clk_i);
    iob_valid_i <= 1'b1;
    iob_addr_i  <= addr;
    iob_wdata_i <= wdata;
    iob_wstrb_i <= wstrb;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) stop_run("Timeout: the request was never accepted");
    end while (!iob_ready_o);
    @(posedge clk_i);
    iob_valid_i <= 1'b0;
    iob_wstrb_i <= '0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) stop_run("Timeout: the request never completed");
      if (!iob_ready_o) begin
        check_value("iob_rvalid_o before completion", iob_rvalid_o, 1'b0);
      end
    end while (!iob_ready_o);
    check_value("iob_rvalid_o", iob_rvalid_o, wstrb == '0);
    rdata = iob_rdata_o;
    lat   = n;
  endtask

  task automatic cache_read(input int widx);
    word_t rdata;
    int    lat;
    int    line;
    int    idx;
    logic  hit;
    line = widx / `CACHE_WORDS;
    idx  = line % `CACHE_LINES;
    hit  = line_valid[idx] && (line_tag[idx] == line);
    transact(32'(widx * 4), '0, '0, rdata, lat);
    check_value("iob_rdata_o", rdata, shadow[widx]);
    if (hit) begin
      exp_hits++;
      check_value("read hit latency", lat, 2);
    end else begin
      // A miss fills the whole line
      exp_misses++;
      check_value("read miss latency above 2", lat > 2, 1);
      line_valid[idx] = 1'b1;
      line_tag[idx]   = line;
    end
  endtask

  task automatic cache_write(input int widx, input word_t wdata, input strb_t wstrb);
    word_t rdata;
    int    lat;
    int    n;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) shadow[widx][8*b +: 8] = wdata[8*b +: 8];
    end
    transact(32'(widx * 4), wdata, wstrb, rdata, lat);
    exp_writes++;
    // The memory takes the write at the edge that closes the ack cycle
    n = 0;
    while (mem_writes != exp_writes) begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) stop_run("Timeout: the write-through never reached memory");
    end
    check_value("memory word after write-through", mem_model_i.mem_q[widx], shadow[widx]);
  endtask

  task automatic csr_read(input int csr, input int expected, input string name);
    word_t rdata;
    int    lat;
    transact(CSR_BASE | 32'(csr * 4), '0, '0, rdata, lat);
    check_value(name, rdata, expected);
    check_value("CSR read latency", lat, 1);
  endtask

  task automatic invalidate_all();
    word_t rdata;
    int    lat;
    transact(CSR_BASE | 32'(`CACHE_CSR_INVALIDATE * 4), 32'h1, 4'hf, rdata, lat);
    check_value("CSR write latency", lat, 1);
    for (int i = 0; i < `CACHE_LINES; i++) line_valid[i] = 1'b0;
  endtask

  task automatic check_counters();
    csr_read(`CACHE_CSR_HITS, exp_hits, "hit counter CSR");
    csr_read(`CACHE_CSR_MISSES, exp_misses, "miss counter CSR");
  endtask

  // Memory side protocol watch
  always @(negedge clk_i) begin
    if (!reset_i) begin
      check_value("mem_model credit_err_o", credit_err, 1'b0);
      check_value("mem_model addr_err_o", addr_err, 1'b0);
    end
  end

  initial begin
    int widx;
    int kind;
    void'($urandom(92631));
    reset_i     = 1'b1;
    iob_valid_i = 1'b0;
    iob_addr_i  = '0;
    iob_wdata_i = '0;
    iob_wstrb_i = '0;
    exp_hits    = 0;
    exp_misses  = 0;
    exp_writes  = 0;
    for (int i = 0; i < `CACHE_LINES; i++) begin
      line_valid[i] = 1'b0;
      line_tag[i]   = 0;
    end
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_value("iob_ready_o after reset", iob_ready_o, 1'b1);
    check_value("iob_rvalid_o after reset", iob_rvalid_o, 1'b0);
    check_value("mem_req_o after reset", mem_req_o, 1'b0);
    for (int i = 0; i < MEM_WORDS; i++) shadow[i] = mem_model_i.mem_q[i];
    check_counters();

    // Cache one line, drop everything, then it must miss again
    cache_read(5);
    cache_read(5);
    invalidate_all();
    cache_read(5);
    check_counters();

    for (int op = 0; op < NUM_OPS; op++) begin
      widx = $urandom_range(0, ADDR_WORDS - 1);
      kind = $urandom_range(0, 99);
      if (kind < 55) cache_read(widx);
      else if (kind < 92) cache_write(widx, $urandom(), strb_t'($urandom_range(1, 15)));
      else if (kind < 98) check_counters();
      else invalidate_all();
    end
    check_counters();

    $display("all tests passed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+common
common/cache_pkg.sv
front_end/cache_front_end.sv
hdl/cache_memory.sv
hdl/cache_control.sv
hdl/cache_back_end.sv
hdl/cache_top.sv
dv/cache_mem_model.sv
dv/cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module cache_tb -o cache_sim

# The testbench reports its own result, so the exit status is read from the log
./obj_dir/cache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "all tests passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
